/* sim/decode_golden.txt */
// valid instr wb_en wb_rd wb_data exp_ctrl exp_imm exp_rs1_data exp_rs2_data
// ctrl bits: alu_op[11:8] src_b_imm src_a_pc reg_write mem_read mem_write branch jump illegal
0 00000000 0 00 00000000 000 00000000 00000000 00000000 // idle after reset
0 00000000 1 01 11111111 000 00000000 00000000 00000000 // write x1
0 00000000 1 02 a5a50002 000 00000000 00000000 00000000 // write x2
1 002081b3 0 00 00000000 020 00000000 11111111 a5a50002 // add x3,x1,x2
1 40110233 0 00 00000000 120 00000000 a5a50002 11111111 // sub x4,x2,x1
1 022082b3 0 00 00000000 001 00000000 11111111 a5a50002 // OP with reserved func7
1 fff08313 0 00 00000000 0a0 ffffffff 11111111 00000000 // addi x6,x1,-1
1 7ff00393 0 00 00000000 0a0 000007ff 00000000 00000000 // addi x7,x0,2047
1 41115413 0 00 00000000 7a0 00000011 a5a50002 00000000 // srai x8,x2,17
1 ffc12503 0 00 00000000 0b0 fffffffc a5a50002 00000000 // lw x10,-4(x2)
0 00000000 0 00 00000000 000 00000000 00000000 00000000 // gap in the stream
1 00112423 0 00 00000000 088 00000008 a5a50002 11111111 // sw x1,8(x2)
1 fe20a623 0 00 00000000 088 ffffffec 11111111 a5a50002 // sw x2,-20(x1)
1 fe208ce3 0 00 00000000 104 fffffffc 11111111 a5a50002 // beq x1,x2,-8
1 0020e863 0 00 00000000 404 00000008 11111111 a5a50002 // bltu x1,x2,16
1 100000ef 0 00 00000000 0e2 00000080 00000000 00000000 // jal x1,256
1 ffdff06f 0 00 00000000 0e2 fffffffe 00000000 00000000 // jal x0,-4
1 00c100e7 0 00 00000000 0a2 0000000c a5a50002 00000000 // jalr x1,12(x2)
1 fffff1b7 0 00 00000000 aa0 fffff000 00000000 00000000 // lui x3,0xfffff
1 12345217 0 00 00000000 0e0 12345000 00000000 00000000 // auipc x4,0x12345
1 ffffffff 0 00 00000000 001 00000000 00000000 00000000 // unknown opcode
1 000001b3 1 00 deadbeef 020 00000000 00000000 00000000 // write to x0 is dropped
1 00128333 1 05 cafe0005 020 00000000 cafe0005 11111111 // read of x5 bypassed
1 405083b3 0 00 00000000 120 00000000 11111111 cafe0005 // x5 read from the file
0 00000000 0 00 00000000 000 00000000 00000000 00000000 // idle tail

/* rv_decode.f */
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/imm_gen.sv
hw/ctrl_decode.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/rv_decode_top.sv
sim/decode_checker.sv
sim/tb_rv_decode.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_decode.f --top-module tb_rv_decode

out=$(./obj_dir/Vtb_rv_decode)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

/* sim/tb_rv_decode.sv */
`timescale 1ns/1ps

module tb_rv_decode;

    // Each golden record is nine hex words, see the header of the data file
    localparam int REC_WORDS   = 9;
    localparam int MAX_RECORDS = 64;
    localparam int GOLD_WORDS  = REC_WORDS * MAX_RECORDS;
    localparam int RESET_LIMIT = 20;
    localparam int DRAIN_LIMIT = 50;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    instr_valid;
    rv_isa_pkg::rv_instr_u   instr;
    rv_ctrl_pkg::wb_t        wb;
    logic                    id_valid;
    rv_ctrl_pkg::id_bundle_t id;
    logic [31:0]             rs1_data;
    logic [31:0]             rs2_data;

    // Expected values travel next to the stimulus and the checker delays them
    logic [11:0] exp_ctrl;
    logic [31:0] exp_imm;
    logic [31:0] exp_rs1_data;
    logic [31:0] exp_rs2_data;
    int          n_tests;
    int          n_errors;

    logic [31:0] golden [0:GOLD_WORDS-1];

    always #50 clk = ~clk;

    // Reset is held over the first three rising edges
    initial
    begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

    rv_decode_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .id_valid    (id_valid),
        .id          (id),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    decode_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .exp_valid    (instr_valid),
        .exp_instr    (instr),
        .exp_ctrl     (exp_ctrl),
        .exp_imm      (exp_imm),
        .exp_rs1_data (exp_rs1_data),
        .exp_rs2_data (exp_rs2_data),
        .id_valid     (id_valid),
        .id           (id),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .n_tests      (n_tests),
        .n_errors     (n_errors)
    );

    // Called right after a rising edge, so every input changes through the NBA region
    task automatic apply_record(input int base);
        instr_valid  <= golden[base][0];
        instr        <= golden[base + 1];
        wb.en        <= golden[base + 2][0];
        wb.rd        <= golden[base + 3][4:0];
        wb.data      <= golden[base + 4];
        exp_ctrl     <= golden[base + 5][11:0];
        exp_imm      <= golden[base + 6];
        exp_rs1_data <= golden[base + 7];
        exp_rs2_data <= golden[base + 8];
    endtask

    task automatic apply_idle();
        instr_valid  <= 1'b0;
        instr        <= '0;
        wb           <= '0;
        exp_ctrl     <= '0;
        exp_imm      <= '0;
        exp_rs1_data <= '0;
        exp_rs2_data <= '0;
    endtask

    initial
    begin
        int   n_records;
        int   n_valid;
        int   cycles;
        logic timed_out;
        apply_idle();
        timed_out = 1'b0;
        n_records = 0;
        n_valid   = 0;
        // Every word outside the file holds a valid field above one, which ends the table
        for (int i = 0; i < GOLD_WORDS; i++)
            golden[i] = {16'hdead, i[15:0]};
        $readmemh("sim/decode_golden.txt", golden);
        while (n_records < MAX_RECORDS && golden[n_records * REC_WORDS] <= 32'd1)
        begin
            if (golden[n_records * REC_WORDS][0])
                n_valid++;
            n_records++;
        end
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1)
        begin
            $display("Timeout: reset was not released within %0d cycles", RESET_LIMIT);
            timed_out = 1'b1;
        end
        else
        begin
            // One record per clock, valid records back to back as the file lists them
            for (int r = 0; r < n_records; r++)
            begin
                apply_record(r * REC_WORDS);
                @(posedge clk);
            end
            apply_idle();
            cycles = 0;
            while (n_tests < n_valid && cycles < DRAIN_LIMIT)
            begin
                @(posedge clk);
                cycles++;
            end
            if (n_tests < n_valid)
            begin
                $display("Timeout: only %0d of %0d instructions left the decode stage",
                         n_tests, n_valid);
                timed_out = 1'b1;
            end
        end
        if (n_valid == 0)
            $display("The golden file holds no valid instruction records");
        $display("Summary: %0d tests checked, %0d mismatches", n_tests, n_errors);
        if (!timed_out && n_valid > 0 && n_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* sim/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    exp_valid,
    input  logic [31:0]             exp_instr,
    input  logic [11:0]             exp_ctrl,
    input  logic [31:0]             exp_imm,
    input  logic [31:0]             exp_rs1_data,
    input  logic [31:0]             exp_rs2_data,
    input  logic                    id_valid,
    input  rv_ctrl_pkg::id_bundle_t id,
    input  logic [31:0]             rs1_data,
    input  logic [31:0]             rs2_data,
    output int                      n_tests,
    output int                      n_errors
);

    logic        valid_q;
    logic [31:0] instr_q;
    logic [11:0] ctrl_q;
    logic [31:0] imm_q;
    logic [31:0] rs1_q;
    logic [31:0] rs2_q;
    logic [11:0] ctrl_seen;
    int          tests_done = 0;
    int          errors = 0;
    int          test_bad;

    assign ctrl_seen = id.ctrl;
    assign n_tests   = tests_done;
    assign n_errors  = errors;

    // The stage has a fixed latency of one edge, so the expectation is delayed by one
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
            instr_q <= '0;
            ctrl_q  <= '0;
            imm_q   <= '0;
            rs1_q   <= '0;
            rs2_q   <= '0;
        end
        else
        begin
            valid_q <= exp_valid;
            instr_q <= exp_instr;
            ctrl_q  <= exp_ctrl;
            imm_q   <= exp_imm;
            rs1_q   <= exp_rs1_data;
            rs2_q   <= exp_rs2_data;
        end
    end

    task automatic check_field(input string name, input logic [31:0] seen,
                               input logic [31:0] want);
        if (seen !== want)
        begin
            $display("ERR %s test %0d: got %h expected %h", name, tests_done + 1, seen, want);
            test_bad++;
        end
    endtask

    // Outputs are compared in the middle of the cycle, well away from the edges
    always @(negedge clk)
    begin
        if (rst_n && valid_q)
        begin
            test_bad = 0;
            check_field("id_valid", {31'd0, id_valid}, 32'd1);
            check_field("id.ctrl", {20'd0, ctrl_seen}, {20'd0, ctrl_q});
            check_field("id.imm", id.imm, imm_q);
            // Register fields sit at the same bit positions in every RV32I format
            check_field("id.rd", {27'd0, id.rd}, {27'd0, instr_q[11:7]});
            check_field("id.rs1", {27'd0, id.rs1}, {27'd0, instr_q[19:15]});
            check_field("id.rs2", {27'd0, id.rs2}, {27'd0, instr_q[24:20]});
            check_field("id.func3", {29'd0, id.func3}, {29'd0, instr_q[14:12]});
            check_field("rs1_data", rs1_data, rs1_q);
            check_field("rs2_data", rs2_data, rs2_q);
            if (test_bad == 0)
                $display("Test %0d instr %h passed", tests_done + 1, instr_q);
            else
                $display("Test %0d instr %h failed with %0d mismatches",
                         tests_done + 1, instr_q, test_bad);
            errors += test_bad;
            tests_done++;
        end
        else if (rst_n && id_valid !== 1'b0)
        begin
            // No strobe one edge ago, so the stage must stay quiet
            $display("ERR id_valid idle cycle: got %h expected %h", id_valid, 1'b0);
            errors++;
        end
    end

endmodule

/* hw/rv_decode_top.sv */
`timescale 1ns/1ps

module rv_decode_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  rv_isa_pkg::rv_instr_u   instr,
    input  rv_ctrl_pkg::wb_t        wb,
    output logic                    id_valid,
    output rv_ctrl_pkg::id_bundle_t id,
    output logic [31:0]             rs1_data,
    output logic [31:0]             rs2_data
);

    // Source register addresses, straight from the incoming instruction
    logic [4:0] rs1;
    logic [4:0] rs2;

    decode_unit u_decode_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1         (rs1),
        .rs2         (rs2),
        .id_valid    (id_valid),
        .id          (id)
    );

    // Read data comes back one edge later, in step with id
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  rv_isa_pkg::rv_instr_u   instr,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic                    id_valid,
    output rv_ctrl_pkg::id_bundle_t id
);

    rv_ctrl_pkg::ctrl_t      ctrl;
    logic [31:0]             imm;
    rv_ctrl_pkg::id_bundle_t id_d;

    ctrl_decode u_ctrl_decode (
        .instr (instr),
        .ctrl  (ctrl)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    // Read addresses leave unregistered so the register file answers with the bundle
    assign rs1 = instr.r_fmt.rs1;
    assign rs2 = instr.r_fmt.rs2;

    assign id_d = '{ctrl: ctrl, rd: instr.r_fmt.rd, rs1: instr.r_fmt.rs1,
                    rs2: instr.r_fmt.rs2, func3: instr.r_fmt.func3, imm: imm};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            id_valid <= 1'b0;
            id       <= '0;
        end
        else
        begin
            // The strobe follows every instruction, the bundle holds between them
            id_valid <= instr_valid;
            if (instr_valid)
                id <= id_d;
        end
    end

    // Nothing left over from before reset may show up on the first live edge
    a_no_valid_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !id_valid);

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    input  rv_ctrl_pkg::wb_t   wb,
    output logic [31:0]        rs1_data,
    output logic [31:0]        rs2_data
);

    logic [31:0] regs [0:31];
    logic        wb_we;
    logic        byp1;
    logic        byp2;

    // Writes to x0 are dropped here, so entry zero keeps its reset value forever
    assign wb_we = wb.en && (wb.rd != 5'd0);

    // A read that hits the register being written this cycle takes the new data
    assign byp1 = wb_we && (wb.rd == rs1);
    assign byp2 = wb_we && (wb.rd == rs2);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
            rs1_data <= 32'd0;
            rs2_data <= 32'd0;
        end
        else
        begin
            if (wb_we)
                regs[wb.rd] <= wb.data;
            rs1_data <= byp1 ? wb.data : regs[rs1];
            rs2_data <= byp2 ? wb.data : regs[rs2];
        end
    end

    // x0 reads zero on both ports, even when write-back aims at it
    a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == 5'd0) |=> (rs1_data == 32'd0));
    a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2 == 5'd0) |=> (rs2_data == 32'd0));

endmodule

/* hw/ctrl_decode.sv */
`timescale 1ns/1ps

module ctrl_decode (
    input  rv_isa_pkg::rv_instr_u instr,
    output rv_ctrl_pkg::ctrl_t    ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       f7_base;
    logic       f7_alt;
    logic       is_sr;
    logic       is_shift;

    assign opcode   = instr.r_fmt.opcode;
    assign func3    = instr.r_fmt.func3;
    assign func7    = instr.r_fmt.func7;
    assign f7_base  = (func7 == rv_isa_pkg::F7_BASE);
    assign f7_alt   = (func7 == rv_isa_pkg::F7_ALT);
    assign is_sr    = (func3 == rv_isa_pkg::F3_SRL_SRA);
    assign is_shift = is_sr || (func3 == rv_isa_pkg::F3_SLL);

    // OP and OP-IMM share the func3 table, alt picks SUB or SRA
    function automatic rv_ctrl_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        rv_ctrl_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     op = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = rv_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = rv_ctrl_pkg::ALU_OR;
            default:                op = rv_ctrl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl = '0;
        ctrl.alu_op = rv_ctrl_pkg::ALU_ADD;
        case (opcode)
            rv_isa_pkg::OPC_LUI:
            begin
                // The immediate already sits in the upper bits, so it passes straight through
                ctrl.alu_op    = rv_ctrl_pkg::ALU_PASS_B;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC:
            begin
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_JAL:
            begin
                // The ALU forms the target from PC and offset, the link is written back
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            rv_isa_pkg::OPC_JALR:
            begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH:
            begin
                // Equality tests subtract, ordered ones compare signed or unsigned
                ctrl.branch = 1'b1;
                if (func3[2])
                    ctrl.alu_op = func3[1] ? rv_ctrl_pkg::ALU_SLTU : rv_ctrl_pkg::ALU_SLT;
                else
                    ctrl.alu_op = rv_ctrl_pkg::ALU_SUB;
            end
            rv_isa_pkg::OPC_LOAD:
            begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            rv_isa_pkg::OPC_STORE:
            begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM:
            begin
                ctrl.src_b_imm = 1'b1;
                // ADDI has no SUB form, the upper immediate bits only matter for shifts
                ctrl.alu_op = alu_from_f3(func3, is_sr && f7_alt);
                // An illegal instruction must not change architectural state
                if (is_shift && !(f7_base || (is_sr && f7_alt)))
                    ctrl.illegal = 1'b1;
                else
                    ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP:
            begin
                ctrl.alu_op = alu_from_f3(func3, f7_alt);
                // The alternate func7 exists only for SUB and SRA
                if (!(f7_base || (f7_alt && (is_sr || func3 == rv_isa_pkg::F3_ADD_SUB))))
                    ctrl.illegal = 1'b1;
                else
                    ctrl.reg_write = 1'b1;
            end
            default:
                // FENCE, SYSTEM and anything unknown end up here
                ctrl.illegal = 1'b1;
        endcase
    end

    // Execute trusts the write enables, so a trapped instruction must carry none of them
    always_comb
    begin
        assert (!(ctrl.illegal && (ctrl.reg_write || ctrl.mem_write)))
            else $error("ctrl_decode: illegal instruction with a write enable set");
    end

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  rv_isa_pkg::rv_instr_u instr,
    output logic [31:0]           imm
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       is_shift;

    // Every view shares the low seven bits, so any one of them gives the opcode
    assign opcode = instr.i_fmt.opcode;
    assign func3  = instr.i_fmt.func3;

    // SLLI, SRLI and SRAI carry a shift amount instead of a signed immediate
    assign is_shift = (func3 == rv_isa_pkg::F3_SLL) || (func3 == rv_isa_pkg::F3_SRL_SRA);

    always_comb
    begin
        imm = 32'd0;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM:
            begin
                if (is_shift)
                    // The shamt sits where rs2 would be, and it is never negative
                    imm = {27'd0, instr.r_fmt.rs2};
                else
                    imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            end
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_JALR:
                imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            rv_isa_pkg::OPC_STORE:
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            // Branch and jump offsets stay in halfwords, the branch unit shifts them
            rv_isa_pkg::OPC_BRANCH:
                imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1};
            rv_isa_pkg::OPC_JAL:
                imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1};
            // LUI and AUIPC load the upper twenty bits with the low twelve cleared
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:
                imm = {instr.u_fmt.imm_31_12, 12'd0};
            default:
                // R-type and every opcode we do not decode has no immediate
                imm = 32'd0;
        endcase
    end

endmodule

/* hw/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // Operations the execute stage ALU knows about
    // PASS_B forwards operand B untouched, which LUI relies on
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Control word handed to execute, twelve bits
    typedef struct packed {
        alu_op_e alu_op;
        // Operand B comes from the immediate instead of rs2
        logic    src_b_imm;
        // Operand A comes from the PC instead of rs1
        logic    src_a_pc;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    illegal;
    } ctrl_t;

    // Everything the stage registers for one instruction
    typedef struct packed {
        ctrl_t       ctrl;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  func3;
        logic [31:0] imm;
    } id_bundle_t;

    // Write-back port coming from the end of the pipe
    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the RV32I base set that the decoder accepts
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU func3 encodings, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // The only two func7 values defined for the base integer set
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Format views, most significant field first
    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied and never encoded
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word seen through each format, the opcode lines up in all of them
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_u;

endpackage
